//--- common/fir_pkg.sv
/* Shared sample, coefficient and accumulator types
   Half-band coefficient set and converter frame constants */
package fir_pkg;

	// Converter code in offset binary, MID_CODE is zero
	typedef logic [11:0] sample_t;

	// Filter coefficient in Q1.10
	typedef logic signed [11:0] coef_t;

	// Wide enough for the full folded sum
	typedef logic signed [25:0] acc_t;

	parameter int NUM_TAPS = 11;

	// Half-band set, odd taps zero except the centre, sum is 1024
	parameter coef_t HB_COEFS [NUM_TAPS] = '{
		6, 0, -50, 0, 300, 512, 300, 0, -50, 0, 6
	};

	parameter int COEF_SHIFT = 10;     // Q1.10 back to integer

	// ADC frame is 4 leading zeros and 12 data bits
	// DAC frame is 2 don't-care bits, 2 mode bits and 12 data bits
	parameter int FRAME_BITS = 16;

	parameter int MID_CODE = 2048;     // Zero level of sample_t

endpackage

//--- common/adc_if.sv
/* Start and done handshake plus both channel words
   between the sample sequencer and the ADC reader */
`timescale 1ns/1ps

interface adc_if;

	logic             start;       // One-cycle pulse from sequencer
	logic             done;        // One-cycle pulse, words valid
	fir_pkg::sample_t ch0_data;    // Held until the next start
	fir_pkg::sample_t ch1_data;

	modport master (
		output start,
		input  done,
		input  ch0_data,
		input  ch1_data
	);

	modport slave (
		input  start,
		output done,
		output ch0_data,
		output ch1_data
	);

endinterface

//--- adc/adc_serial_rx.sv
/* Two-channel serial ADC frame reader
   Drives chip select and the enabled serial clock, samples both data lines */
`timescale 1ns/1ps

module adc_serial_rx #(
	parameter int SCK_DIV = 2
) (
	input  logic firclk,
	input  logic rst_n,
	adc_if.slave ctl,
	input  logic sdata0,
	input  logic sdata1,
	output logic cs_n,
	output logic sck
);

	localparam int DIV_W = $clog2(SCK_DIV + 1);
	localparam int BIT_W = $clog2(fir_pkg::FRAME_BITS);

	typedef enum logic [1:0] {RX_IDLE, RX_SHIFT, RX_DONE} rx_state_t;

	rx_state_t                      state;
	logic [DIV_W-1:0]               div_cnt;
	logic [BIT_W-1:0]               bit_cnt;
	logic [fir_pkg::FRAME_BITS-1:0] shift0;
	logic [fir_pkg::FRAME_BITS-1:0] shift1;
	logic                           sck_edge;

	assign sck_edge = (div_cnt == DIV_W'(SCK_DIV - 1));     // Half period elapsed

	always_ff @(posedge firclk)
	begin
		if (!rst_n)
		begin
			state   <= RX_IDLE;
			cs_n    <= 1'b1;
			sck     <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				RX_IDLE:
				begin
					if (ctl.start)
					begin
						cs_n    <= 1'b0;                     // Setup cycle
						div_cnt <= '0;
						bit_cnt <= '0;
						state   <= RX_SHIFT;
					end
				end
				RX_SHIFT:
				begin
					if (sck_edge)
					begin
						div_cnt <= '0;
						sck     <= ~sck;
						// Bit ends on the falling edge
						if (sck && bit_cnt == BIT_W'(fir_pkg::FRAME_BITS - 1))
						begin
							cs_n  <= 1'b1;                   // Release
							state <= RX_DONE;
						end
						else if (sck)
							bit_cnt <= bit_cnt + 1'b1;
					end
					else
						div_cnt <= div_cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;                        // Done lasts one cycle
			endcase
		end
	end

	// Sample both lines on the rising serial clock
	always_ff @(posedge firclk)
	begin
		if (state == RX_SHIFT && sck_edge && !sck)
		begin
			shift0 <= {shift0[fir_pkg::FRAME_BITS-2:0], sdata0};
			shift1 <= {shift1[fir_pkg::FRAME_BITS-2:0], sdata1};
		end
	end

	assign ctl.done     = (state == RX_DONE);
	assign ctl.ch0_data = fir_pkg::sample_t'(shift0);      // Leading zeros dropped
	assign ctl.ch1_data = fir_pkg::sample_t'(shift1);

	// Sequencer must wait for done before the next conversion
	a_start_when_idle: assert property (
		@(posedge firclk) disable iff (!rst_n)
		ctl.start |-> state == RX_IDLE
	);

endmodule

//--- dac/dac_serial_tx.sv
/* Serial DAC frame writer with sync and enabled serial clock
   Data changes on the falling clock, MSB first */
`timescale 1ns/1ps

module dac_serial_tx #(
	parameter int SCK_DIV = 2
) (
	input  logic             firclk,
	input  logic             rst_n,
	input  logic             start,
	input  fir_pkg::sample_t data,
	output logic             done,
	output logic             sync_n,
	output logic             sck,
	output logic             sdata
);

	localparam int DIV_W = $clog2(SCK_DIV + 1);
	localparam int BIT_W = $clog2(fir_pkg::FRAME_BITS);

	typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_DONE} tx_state_t;

	tx_state_t                      state;
	logic [DIV_W-1:0]               div_cnt;
	logic [BIT_W-1:0]               bit_cnt;
	logic [fir_pkg::FRAME_BITS-1:0] shreg;
	logic                           sck_edge;

	assign sck_edge = (div_cnt == DIV_W'(SCK_DIV - 1));

	always_ff @(posedge firclk)
	begin
		if (!rst_n)
		begin
			state   <= TX_IDLE;
			sync_n  <= 1'b1;
			sck     <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			shreg   <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (start)
					begin
						shreg   <= {2'b00, 2'b00, data};     // Don't-care, mode, data
						sync_n  <= 1'b0;
						div_cnt <= '0;
						bit_cnt <= '0;
						state   <= TX_SHIFT;
					end
				end
				TX_SHIFT:
				begin
					if (sck_edge)
					begin
						div_cnt <= '0;
						sck     <= ~sck;
						if (sck)
						begin
							shreg <= shreg << 1;             // Next bit on falling edge
							if (bit_cnt == BIT_W'(fir_pkg::FRAME_BITS - 1))
							begin
								sync_n <= 1'b1;
								state  <= TX_DONE;
							end
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end
					else
						div_cnt <= div_cnt + 1'b1;
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	assign sdata = shreg[fir_pkg::FRAME_BITS-1];
	assign done  = (state == TX_DONE);

	// Sequencer only starts a frame after the previous done
	a_start_when_synced: assert property (
		@(posedge firclk) disable iff (!rst_n)
		start |-> sync_n
	);

endmodule

//--- fir/halfband_fir.sv
/* Credit-fed 11-tap half-band FIR with input queue
   Folded symmetric multiply-accumulate over the nonzero taps, saturated output */
`timescale 1ns/1ps

module halfband_fir #(
	parameter int FIR_DEPTH = 2
) (
	input  logic             firclk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  fir_pkg::sample_t in_data,
	output logic             in_credit,
	output logic             out_valid,
	output fir_pkg::sample_t out_data,
	input  logic             out_credit
);

	localparam int PTR_W     = (FIR_DEPTH > 1) ? $clog2(FIR_DEPTH) : 1;
	localparam int CNT_W     = $clog2(FIR_DEPTH + 1);
	localparam int SW        = $bits(fir_pkg::sample_t);
	localparam int CENTRE    = fir_pkg::NUM_TAPS / 2;
	localparam int MAC_STEPS = (fir_pkg::NUM_TAPS + 5) / 4;    // Even pairs plus centre
	localparam int IDX_W     = $clog2(MAC_STEPS);

	typedef enum logic [1:0] {FIR_IDLE, FIR_MAC, FIR_SCALE, FIR_HOLD} fir_state_t;

	fir_state_t          state;
	fir_pkg::sample_t    queue [FIR_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    q_count;
	logic                pop;
	logic signed [SW-1:0] taps [fir_pkg::NUM_TAPS];            // Delay line, signed offset
	logic [IDX_W-1:0]    mac_idx;
	int                  tap_k;
	logic signed [SW:0]  pre_sum;
	fir_pkg::coef_t      coef;
	fir_pkg::acc_t       acc;
	fir_pkg::acc_t       scaled;
	fir_pkg::sample_t    result;
	logic [1:0]          out_cred;
	logic                emit;

	assign pop  = (state == FIR_IDLE) && (q_count != '0);
	assign emit = (state == FIR_SCALE || state == FIR_HOLD) && (out_cred != 2'd0);

	// Folded pair for the current MAC step
	always_comb
	begin
		tap_k = (mac_idx == IDX_W'(MAC_STEPS - 1)) ? CENTRE : 2 * int'(mac_idx);
		coef  = fir_pkg::HB_COEFS[tap_k];
		if (tap_k == CENTRE)
			pre_sum = taps[tap_k];
		else
			pre_sum = taps[tap_k] + taps[fir_pkg::NUM_TAPS-1-tap_k];
	end

	// Floor shift, back to offset binary, clamp to code range
	always_comb
	begin
		scaled = (acc >>> fir_pkg::COEF_SHIFT) + fir_pkg::acc_t'(fir_pkg::MID_CODE);
		if (scaled < 0)
			result = '0;
		else if (scaled > fir_pkg::acc_t'(2**SW - 1))
			result = '1;
		else
			result = fir_pkg::sample_t'(scaled);
	end

	always_ff @(posedge firclk)
	begin
		if (!rst_n)
		begin
			state     <= FIR_IDLE;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			q_count   <= '0;
			mac_idx   <= '0;
			acc       <= '0;
			in_credit <= 1'b0;
			out_valid <= 1'b0;
			out_cred  <= 2'd1;                           // One result slot downstream
			for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
				taps[i] <= '0;
		end
		else
		begin
			in_credit <= pop;                            // Slot freed
			out_valid <= emit;
			out_cred  <= out_cred + 2'(out_credit) - 2'(emit);
			q_count   <= q_count + CNT_W'(in_valid) - CNT_W'(pop);
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_W'(FIR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
			begin
				rd_ptr  <= (rd_ptr == PTR_W'(FIR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				taps[0] <= $signed(queue[rd_ptr] - fir_pkg::sample_t'(fir_pkg::MID_CODE));
				for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--)
					taps[i] <= taps[i-1];
			end
			case (state)
				FIR_IDLE:
				begin
					if (pop)
					begin
						acc     <= '0;
						mac_idx <= '0;
						state   <= FIR_MAC;
					end
				end
				FIR_MAC:
				begin
					acc     <= acc + pre_sum * coef;
					mac_idx <= mac_idx + 1'b1;
					if (mac_idx == IDX_W'(MAC_STEPS - 1))
						state <= FIR_SCALE;
				end
				FIR_SCALE:
					state <= emit ? FIR_IDLE : FIR_HOLD;     // Wait for a credit
				default:
				begin
					if (emit)
						state <= FIR_IDLE;
				end
			endcase
		end
	end

	// Queue storage and result register
	always_ff @(posedge firclk)
	begin
		if (in_valid)
			queue[wr_ptr] <= in_data;
		if (emit)
			out_data <= result;
	end

	// Sender spends a credit per sample, so a full queue never sees a push
	a_no_overflow: assert property (
		@(posedge firclk) disable iff (!rst_n)
		in_valid |-> q_count < CNT_W'(FIR_DEPTH)
	);

	a_out_cred_max: assert property (
		@(posedge firclk) disable iff (!rst_n)
		out_cred <= 2'd1
	);

endmodule

//--- hw/sample_sequencer.sv
/* Sample-rate pacing, channel select and bypass routing
   Credit accounting toward the filter and the one-entry result slot */
`timescale 1ns/1ps

module sample_sequencer #(
	parameter int SAMPLE_DIV = 256,
	parameter int FIR_DEPTH  = 2
) (
	input  logic             firclk,
	input  logic             rst_n,
	input  logic             chan_sel,
	input  logic             bypass,
	adc_if.master            adc,
	output logic             dac_start,
	output fir_pkg::sample_t dac_data,
	input  logic             dac_done,
	output logic             fir_valid,
	output fir_pkg::sample_t fir_data,
	input  logic             fir_credit,
	input  logic             res_valid,
	input  fir_pkg::sample_t res_data,
	output logic             res_credit,
	output logic             overrun
);

	localparam int TICK_W = $clog2(SAMPLE_DIV);
	localparam int CRED_W = $clog2(FIR_DEPTH + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic              adc_busy;       // Conversion outstanding
	logic              dac_busy;
	logic [CRED_W-1:0] fir_cred;
	fir_pkg::sample_t  word;
	fir_pkg::sample_t  slot;
	logic              slot_full;
	logic              slot_fir;       // Slot holds a filter result
	logic              handoff;
	logic              slot_free;
	logic              send;
	logic              bypass_load;
	logic              drop_word;
	logic              res_drop;

	assign tick      = (tick_cnt == TICK_W'(SAMPLE_DIV - 1));
	assign word      = chan_sel ? adc.ch1_data : adc.ch0_data;
	assign handoff   = slot_full && !dac_busy;
	assign slot_free = !slot_full || handoff;

	// Filter results take the slot ahead of bypass words
	assign send        = adc.done && !bypass && (fir_cred != '0);
	assign bypass_load = adc.done && bypass && slot_free && !res_valid;
	assign drop_word   = adc.done && (bypass ? !bypass_load : (fir_cred == '0));
	assign res_drop    = res_valid && !slot_free;

	always_ff @(posedge firclk)
	begin
		if (!rst_n)
		begin
			tick_cnt   <= '0;
			adc.start  <= 1'b0;
			adc_busy   <= 1'b0;
			dac_start  <= 1'b0;
			dac_busy   <= 1'b0;
			fir_valid  <= 1'b0;
			fir_cred   <= CRED_W'(FIR_DEPTH);
			res_credit <= 1'b0;
			slot_full  <= 1'b0;
			slot_fir   <= 1'b0;
			overrun    <= 1'b0;
		end
		else
		begin
			tick_cnt  <= tick ? '0 : tick_cnt + 1'b1;
			adc.start <= tick && !adc_busy;
			if (tick && !adc_busy)
				adc_busy <= 1'b1;
			else if (adc.done)
				adc_busy <= 1'b0;

			fir_valid <= send;
			fir_cred  <= fir_cred - CRED_W'(send) + CRED_W'(fir_credit);

			dac_start <= handoff;
			if (handoff)
				dac_busy <= 1'b1;
			else if (dac_done)
				dac_busy <= 1'b0;

			// A dropped result still hands its credit back
			res_credit <= (handoff && slot_fir) || res_drop;
			if ((res_valid && slot_free) || bypass_load)
			begin
				slot_full <= 1'b1;
				slot_fir  <= res_valid;
			end
			else if (handoff)
				slot_full <= 1'b0;

			overrun <= overrun | drop_word | res_drop;   // Sticky
		end
	end

	always_ff @(posedge firclk)
	begin
		if (send)
			fir_data <= word;
		if (handoff)
			dac_data <= slot;
		if (res_valid && slot_free)
			slot <= res_data;
		else if (bypass_load)
			slot <= word;
	end

	// Filter must never return more credits than were spent
	a_cred_range: assert property (
		@(posedge firclk) disable iff (!rst_n)
		fir_cred <= CRED_W'(FIR_DEPTH)
	);

endmodule

//--- hw/adda_filter_top.sv
/* Audio filter subsystem top level
   ADC reader, sequencer, half-band FIR and DAC writer on plain ports */
`timescale 1ns/1ps

module adda_filter_top #(
	parameter int SAMPLE_DIV = 256,
	parameter int SCK_DIV    = 2,
	parameter int FIR_DEPTH  = 2
) (
	input  logic firclk,
	input  logic rst_n,
	input  logic chan_sel,
	input  logic bypass,
	input  logic adc_sdata0,
	input  logic adc_sdata1,
	output logic adc_cs_n,
	output logic adc_sck,
	output logic dac_sync_n,
	output logic dac_sck,
	output logic dac_sdata,
	output logic overrun
);

	adc_if adc_link ();

	logic             dac_start;
	logic             dac_done;
	fir_pkg::sample_t dac_data;
	logic             fir_valid;
	fir_pkg::sample_t fir_data;
	logic             fir_credit;
	logic             res_valid;
	fir_pkg::sample_t res_data;
	logic             res_credit;

	adc_serial_rx #(.SCK_DIV(SCK_DIV)) i_adc_rx (
		.firclk (firclk),
		.rst_n  (rst_n),
		.ctl    (adc_link.slave),
		.sdata0 (adc_sdata0),
		.sdata1 (adc_sdata1),
		.cs_n   (adc_cs_n),
		.sck    (adc_sck)
	);

	sample_sequencer #(.SAMPLE_DIV(SAMPLE_DIV), .FIR_DEPTH(FIR_DEPTH)) i_seq (
		.firclk     (firclk),
		.rst_n      (rst_n),
		.chan_sel   (chan_sel),
		.bypass     (bypass),
		.adc        (adc_link.master),
		.dac_start  (dac_start),
		.dac_data   (dac_data),
		.dac_done   (dac_done),
		.fir_valid  (fir_valid),
		.fir_data   (fir_data),
		.fir_credit (fir_credit),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_credit (res_credit),
		.overrun    (overrun)
	);

	halfband_fir #(.FIR_DEPTH(FIR_DEPTH)) i_fir (
		.firclk     (firclk),
		.rst_n      (rst_n),
		.in_valid   (fir_valid),
		.in_data    (fir_data),
		.in_credit  (fir_credit),
		.out_valid  (res_valid),
		.out_data   (res_data),
		.out_credit (res_credit)
	);

	dac_serial_tx #(.SCK_DIV(SCK_DIV)) i_dac_tx (
		.firclk (firclk),
		.rst_n  (rst_n),
		.start  (dac_start),
		.data   (dac_data),
		.done   (dac_done),
		.sync_n (dac_sync_n),
		.sck    (dac_sck),
		.sdata  (dac_sdata)
	);

endmodule

//--- test/adc_dac_models.sv
/* Behavioral serial ADC source with per-channel code queues
   Serial DAC capture model decoding each sync frame */
`timescale 1ns/1ps

module adc_model (
	input  logic cs_n,
	input  logic sck,
	output logic sdata0,
	output logic sdata1
);

	logic [11:0] ch0_codes [$];
	logic [11:0] ch1_codes [$];
	logic [11:0] code0;
	logic [11:0] code1;
	logic [15:0] frame0;
	logic [15:0] frame1;

	initial
	begin
		sdata0 = 1'b0;
		sdata1 = 1'b0;
		frame0 = '0;
		frame1 = '0;
	end

	task automatic clear_codes();
		ch0_codes.delete();
		ch1_codes.delete();
	endtask

	task automatic push_codes(input logic [11:0] c0, input logic [11:0] c1);
		ch0_codes.push_back(c0);
		ch1_codes.push_back(c1);
	endtask

	// Start of frame, an empty queue serves mid scale
	always @(negedge cs_n)
	begin
		code0 = 12'd2048;
		code1 = 12'd2048;
		if (ch0_codes.size() > 0)
			code0 = ch0_codes.pop_front();
		if (ch1_codes.size() > 0)
			code1 = ch1_codes.pop_front();
		frame0 = {4'b0000, code0};      // Leading zeros, MSB first
		frame1 = {4'b0000, code1};
		sdata0 = frame0[15];
		sdata1 = frame1[15];
	end

	// Next bit on the falling serial clock
	always @(negedge sck)
	begin
		if (cs_n === 1'b0)
		begin
			frame0 = frame0 << 1;
			frame1 = frame1 << 1;
			sdata0 = frame0[15];
			sdata1 = frame1[15];
		end
	end

endmodule

module dac_model (
	input logic sync_n,
	input logic sck,
	input logic sdata
);

	logic [11:0] words [$];
	logic [15:0] shreg;
	int          nbits;

	initial
	begin
		shreg = '0;
		nbits = 0;
	end

	task automatic clear_words();
		words.delete();
	endtask

	function automatic int captured_count();
		return words.size();
	endfunction

	function automatic logic [11:0] word_at(input int idx);
		return words[idx];
	endfunction

	always @(negedge sync_n)
		nbits = 0;

	always @(posedge sck)
	begin
		if (sync_n === 1'b0)
		begin
			shreg = {shreg[14:0], sdata};     // Sampled on the rising clock
			nbits = nbits + 1;
		end
	end

	// Only complete frames count, an aborted frame is ignored
	always @(posedge sync_n)
	begin
		if (nbits == 16)
			words.push_back(shreg[11:0]);
		nbits = 0;
	end

endmodule

//--- test/tb_adda_filter.sv
/* Directed tests for the audio filter subsystem
   Clock, reset, reference filter model, check task and timeouts */
`timescale 1ns/1ps

module tb_adda_filter;

	localparam int SAMPLE_DIV = 256;
	localparam int MID        = 2048;
	localparam int MAX_WORDS  = 64;

	logic        firclk;
	logic        rst_n;
	logic        chan_sel;
	logic        bypass;
	logic        adc_sdata0;
	logic        adc_sdata1;
	logic        adc_cs_n;
	logic        adc_sck;
	logic        dac_sync_n;
	logic        dac_sck;
	logic        dac_sdata;
	logic        overrun;
	logic [11:0] stim0 [MAX_WORDS];     // Channel 0 codes per frame
	logic [11:0] stim1 [MAX_WORDS];
	integer      seed;

	adda_filter_top #(.SAMPLE_DIV(SAMPLE_DIV), .SCK_DIV(2), .FIR_DEPTH(2)) i_adda_filter_top (
		.firclk     (firclk),
		.rst_n      (rst_n),
		.chan_sel   (chan_sel),
		.bypass     (bypass),
		.adc_sdata0 (adc_sdata0),
		.adc_sdata1 (adc_sdata1),
		.adc_cs_n   (adc_cs_n),
		.adc_sck    (adc_sck),
		.dac_sync_n (dac_sync_n),
		.dac_sck    (dac_sck),
		.dac_sdata  (dac_sdata),
		.overrun    (overrun)
	);

	adc_model i_adc_model (.cs_n(adc_cs_n), .sck(adc_sck), .sdata0(adc_sdata0), .sdata1(adc_sdata1));
	dac_model i_dac_model (.sync_n(dac_sync_n), .sck(dac_sck), .sdata(dac_sdata));

	initial
		firclk = 1'b0;

	always #4 firclk = ~firclk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	function automatic int coef_at(input int k);
		case (k)
			0, 10:   return 6;
			2, 8:    return -50;
			4, 6:    return 300;
			5:       return 512;
			default: return 0;
		endcase
	endfunction

	function automatic int floor_div1024(input int value);
		if (value >= 0)
			return value / 1024;
		return -((-value + 1023) / 1024);
	endfunction

	// Direct 11-tap convolution over channel 0, history starts at zero offset
	function automatic int filter_expected(input int n);
		int acc;
		int x;
		int y;
		acc = 0;
		for (int k = 0; k < 11; k++)
		begin
			x = (n - k >= 0) ? int'(stim0[n-k]) - MID : 0;
			acc = acc + coef_at(k) * x;
		end
		y = floor_div1024(acc) + MID;
		if (y < 0)
			y = 0;
		else if (y > 4095)
			y = 4095;
		return y;
	endfunction

	// Reset, then load the first n frames into the ADC model
	task automatic restart(input logic byp, input logic sel, input int n);
		@(posedge firclk);
		rst_n    <= 1'b0;
		bypass   <= byp;
		chan_sel <= sel;
		repeat (5) @(posedge firclk);
		i_adc_model.clear_codes();
		i_dac_model.clear_words();
		for (int i = 0; i < n; i++)
			i_adc_model.push_codes(stim0[i], stim1[i]);
		rst_n <= 1'b1;
	endtask

	task automatic wait_words(input int n);
		int cycles;
		cycles = 0;
		while (i_dac_model.captured_count() < n)
		begin
			@(posedge firclk);
			cycles++;
			if (cycles > n * SAMPLE_DIV + 2000)
			begin
				$display("timeout while waiting for %0d DAC words", n);
				$display("CHECKS FAILED");
				$fatal(1, "DAC output stalled");
			end
		end
		@(negedge firclk);
	endtask

	task automatic check_reset_state();
		restart(1'b0, 1'b0, 0);
		@(posedge firclk);
		@(negedge firclk);
		check_value("adc_cs_n", 1, adc_cs_n);
		check_value("dac_sync_n", 1, dac_sync_n);
		check_value("adc_sck", 0, adc_sck);
		check_value("dac_sck", 0, dac_sck);
		check_value("overrun", 0, overrun);
	endtask

	task automatic test_bypass_select();
		for (int sel = 0; sel < 2; sel++)
		begin
			for (int i = 0; i < 8; i++)
			begin
				stim0[i] = $random(seed);
				stim1[i] = $random(seed);
				if (stim1[i] == stim0[i])
					stim1[i] = stim0[i] ^ 12'h001;     // Keep the channels distinct
			end
			restart(1'b1, sel[0], 8);
			wait_words(8);
			for (int i = 0; i < 8; i++)
				check_value($sformatf("bypass sel %0d word %0d", sel, i),
					sel ? stim1[i] : stim0[i], i_dac_model.word_at(i));
			check_value("overrun", 0, overrun);
		end
	endtask

	task automatic test_impulse();
		int expected;
		for (int i = 0; i < 15; i++)
		begin
			stim0[i] = MID;
			stim1[i] = MID;
		end
		stim0[2] = MID + 1000;
		restart(1'b0, 1'b0, 15);
		wait_words(15);
		for (int i = 0; i < 15; i++)
		begin
			expected = MID;
			if (i >= 2 && i <= 12)
				expected = MID + floor_div1024(1000 * coef_at(i - 2));
			check_value($sformatf("impulse word %0d", i), expected, i_dac_model.word_at(i));
		end
	endtask

	task automatic test_dc_step();
		for (int i = 0; i < 36; i++)
		begin
			stim0[i] = (i < 12) ? 12'd3000 : (i < 24) ? 12'd4095 : 12'd0;
			stim1[i] = MID;
		end
		restart(1'b0, 1'b0, 36);
		wait_words(36);
		check_value("dc word 10", 3000, i_dac_model.word_at(10));     // Unity DC gain
		check_value("dc word 11", 3000, i_dac_model.word_at(11));
		for (int i = 0; i < 36; i++)
			check_value($sformatf("step word %0d", i), filter_expected(i),
				i_dac_model.word_at(i));
	endtask

	task automatic test_nominal_rate();
		for (int i = 0; i < 40; i++)
		begin
			stim0[i] = $random(seed);
			stim1[i] = $random(seed);
		end
		restart(1'b0, 1'b0, 40);
		wait_words(40);
		for (int i = 0; i < 40; i++)
			check_value($sformatf("random word %0d", i), filter_expected(i),
				i_dac_model.word_at(i));
		check_value("overrun", 0, overrun);
	endtask

	initial
	begin
		rst_n    = 1'b0;
		chan_sel = 1'b0;
		bypass   = 1'b0;
		seed     = 32'h334;
		check_reset_state();
		test_bypass_select();
		test_impulse();
		test_dc_step();
		test_nominal_rate();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- files.f
common/fir_pkg.sv
common/adc_if.sv
adc/adc_serial_rx.sv
dac/dac_serial_tx.sv
fir/halfband_fir.sv
hw/sample_sequencer.sv
hw/adda_filter_top.sv
test/adc_dac_models.sv
test/tb_adda_filter.sv
